/* ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

// ------------------------------
// Widths
// ------------------------------
localparam int XLEN      = 32;  // Data and instruction width
localparam int REG_IDX_W = 5;   // x0..x31
localparam int BYTE_EN_W = 4;   // One enable per byte of a word

// ------------------------------
// Encodings
// ------------------------------
// RV32I major opcodes, FENCE and SYSTEM hit the case defaults
typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    I_OP   = 7'b0010011,
    R_OP   = 7'b0110011
} tOpcode;

typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
} tAluOp;

// Values follow funct3 so the decoder can cast directly
typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
} tBranchOp;

typedef enum logic [2:0] {I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE} tImmType;

typedef enum logic [1:0] {WB_ALU, WB_DMEM, WB_PC4} tWbSel;  // Write-back source

// ------------------------------
// Control records
// ------------------------------
typedef struct packed {
    logic [REG_IDX_W-1:0] regDst;
    logic [REG_IDX_W-1:0] regSrc1;
    logic [REG_IDX_W-1:0] regSrc2;
    tAluOp                aluOp;
    tBranchOp             branchOp;
    logic                 lui;              // ALU passes the immediate
    logic                 selAluPc;         // PC on ALU operand A
    logic                 selAluImm;        // Immediate on ALU operand B
    logic                 selNextPcJump;    // JAL or JALR
    logic                 selNextPcBranch;  // Conditional branch
    logic                 regWrEn;
    logic                 dMemWrEn;
    logic                 dMemRdEn;
    logic                 signExt;          // Signed load
    logic [BYTE_EN_W-1:0] dMemByteEn;
    tWbSel                wbSel;
} tDecodedCtrl;

typedef struct packed {
    logic                 valid;   // Valid LOAD in that stage
    logic [REG_IDX_W-1:0] regDst;
} tLoadDst;

typedef struct packed {
    logic selNextPcAluOutQ102H;
} tCtrlIf;

typedef struct packed {
    logic [REG_IDX_W-1:0] regSrc1Q101H;
    logic [REG_IDX_W-1:0] regSrc2Q101H;
    logic [REG_IDX_W-1:0] regDstQ105H;
    logic                 regWrEnQ105H;
} tCtrlRf;

typedef struct packed {
    tAluOp                aluOpQ102H;
    tBranchOp             branchOpQ102H;
    logic                 luiQ102H;
    logic                 selAluPcQ102H;
    logic                 selAluImmQ102H;
    logic [REG_IDX_W-1:0] regSrc1Q102H;
    logic [REG_IDX_W-1:0] regSrc2Q102H;
    logic [REG_IDX_W-1:0] regDstQ103H;   // Forwarding sources from here on
    logic                 regWrEnQ103H;
    logic [REG_IDX_W-1:0] regDstQ104H;
    logic                 regWrEnQ104H;
    logic [REG_IDX_W-1:0] regDstQ105H;
    logic                 regWrEnQ105H;
} tCtrlExe;

typedef struct packed {
    logic                 dMemWrEnQ103H;
    logic                 dMemRdEnQ103H;
    logic [BYTE_EN_W-1:0] dMemByteEnQ103H;
} tCtrlMem;

typedef struct packed {
    logic [BYTE_EN_W-1:0] byteEnQ105H;
    logic                 signExtQ105H;
    tWbSel                wbSelQ105H;
} tCtrlWb;

endpackage

`default_nettype wire

/* instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecoder
    import ctrlPkg::*;
(
    input  logic [XLEN-1:0] instructionQ101H,
    output tDecodedCtrl     ctrlQ101H,
    output logic [XLEN-1:0] immediateQ101H
);

tOpcode     opcode;
logic [2:0] funct3;
logic [6:0] funct7;
logic       isMemAccess;   // LOAD or STORE
tImmType    immType;

// Shared by R_OP and I_OP, alt picks SUB or SRA
function automatic tAluOp aluOpFromFunct(input logic [2:0] f3, input logic alt);
    tAluOp op;
    case (f3)
        3'b000:  op = alt ? SUB : ADD;
        3'b001:  op = SLL;
        3'b010:  op = SLT;
        3'b011:  op = SLTU;
        3'b100:  op = XOR;
        3'b101:  op = alt ? SRA : SRL;
        3'b110:  op = OR;
        default: op = AND;   // 3'b111
    endcase
    return op;
endfunction

// ------------------------------
// Field extraction
// ------------------------------
assign opcode      = tOpcode'(instructionQ101H[6:0]);
assign funct3      = instructionQ101H[14:12];
assign funct7      = instructionQ101H[31:25];
assign isMemAccess = (opcode == LOAD) || (opcode == STORE);

// ------------------------------
// Control bits
// ------------------------------
always_comb begin
    ctrlQ101H.regDst  = instructionQ101H[11:7];
    ctrlQ101H.regSrc1 = instructionQ101H[19:15];
    ctrlQ101H.regSrc2 = instructionQ101H[24:20];

    // ALU operation, address and PC math all use ADD
    case (opcode)
        R_OP:    ctrlQ101H.aluOp = aluOpFromFunct(funct3, funct7[5]);
        I_OP:    ctrlQ101H.aluOp = aluOpFromFunct(funct3, funct7[5] && (funct3 == 3'b101));
        default: ctrlQ101H.aluOp = ADD;
    endcase
    ctrlQ101H.branchOp = (opcode == BRANCH) ? tBranchOp'(funct3) : BEQ;

    // Operand and next-PC selects
    ctrlQ101H.lui             = (opcode == LUI);
    ctrlQ101H.selAluPc        = (opcode == JAL) || (opcode == BRANCH) || (opcode == AUIPC);
    ctrlQ101H.selAluImm       = (opcode != R_OP);   // Only reg-reg uses rs2 on operand B
    ctrlQ101H.selNextPcJump   = (opcode == JAL) || (opcode == JALR);
    ctrlQ101H.selNextPcBranch = (opcode == BRANCH);

    // Enables, FENCE and SYSTEM write nothing
    ctrlQ101H.regWrEn  = (opcode == LUI)  || (opcode == AUIPC) || (opcode == JAL) ||
                         (opcode == JALR) || (opcode == LOAD)  || (opcode == I_OP) ||
                         (opcode == R_OP);
    ctrlQ101H.dMemWrEn = (opcode == STORE);
    ctrlQ101H.dMemRdEn = (opcode == LOAD);
    ctrlQ101H.signExt  = (opcode == LOAD) && !funct3[2];   // LB, LH

    // Access size from funct3
    ctrlQ101H.dMemByteEn = '0;
    if (isMemAccess) begin
        case (funct3[1:0])
            2'b00:   ctrlQ101H.dMemByteEn = 4'b0001;   // Byte
            2'b01:   ctrlQ101H.dMemByteEn = 4'b0011;   // Half
            2'b10:   ctrlQ101H.dMemByteEn = 4'b1111;   // Word
            default: ctrlQ101H.dMemByteEn = '0;
        endcase
    end

    // Write-back source
    if (ctrlQ101H.selNextPcJump) begin
        ctrlQ101H.wbSel = WB_PC4;   // Link address
    end else if (opcode == LOAD) begin
        ctrlQ101H.wbSel = WB_DMEM;
    end else begin
        ctrlQ101H.wbSel = WB_ALU;
    end
end

// ------------------------------
// Immediate generator
// ------------------------------
always_comb begin
    case (opcode)
        LUI, AUIPC: immType = U_TYPE;
        JAL:        immType = J_TYPE;
        BRANCH:     immType = B_TYPE;
        STORE:      immType = S_TYPE;
        default:    immType = I_TYPE;   // JALR, LOAD, I_OP and the rest
    endcase
end

always_comb begin
    case (immType)
        U_TYPE: immediateQ101H = {instructionQ101H[31:12], 12'b0};
        S_TYPE: immediateQ101H = {{20{instructionQ101H[31]}}, instructionQ101H[31:25],
                                  instructionQ101H[11:7]};
        B_TYPE: immediateQ101H = {{20{instructionQ101H[31]}}, instructionQ101H[7],
                                  instructionQ101H[30:25], instructionQ101H[11:8], 1'b0};
        J_TYPE: immediateQ101H = {{12{instructionQ101H[31]}}, instructionQ101H[19:12],
                                  instructionQ101H[20], instructionQ101H[30:21], 1'b0};
        default: immediateQ101H = {{20{instructionQ101H[31]}}, instructionQ101H[31:20]};
    endcase
end

endmodule

`default_nettype wire

/* hazardDetect.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardDetect
    import ctrlPkg::*;
(
    input  logic            Clock,
    input  logic            rstN,
    input  logic            readyQ103H,
    input  logic [XLEN-1:0] instructionQ101H,
    input  tLoadDst         loadQ102H,
    input  tLoadDst         loadQ103H,
    input  logic            jumpQ102H,
    input  logic            branchQ102H,
    input  logic            branchCondMetQ102H,
    output logic            loadHazardQ101H,
    output logic            flushQ102H,
    output logic            flushQ103H
);

tOpcode               opcodeQ101H;
logic [REG_IDX_W-1:0] rs1Q101H;
logic [REG_IDX_W-1:0] rs2Q101H;
logic                 rs2UsedQ101H;   // Only these read rs2 as a register
logic                 rs1Hit;
logic                 rs2Hit;

// Source matches a load result not yet written back
function automatic logic loadMatch(input tLoadDst ld, input logic [REG_IDX_W-1:0] rs);
    return ld.valid && (ld.regDst == rs);
endfunction

// ------------------------------
// Load-use
// ------------------------------
assign opcodeQ101H  = tOpcode'(instructionQ101H[6:0]);
assign rs1Q101H     = instructionQ101H[19:15];
assign rs2Q101H     = instructionQ101H[24:20];
assign rs2UsedQ101H = (opcodeQ101H == R_OP) || (opcodeQ101H == STORE) ||
                      (opcodeQ101H == BRANCH);

assign rs1Hit = loadMatch(loadQ102H, rs1Q101H) || loadMatch(loadQ103H, rs1Q101H);
assign rs2Hit = loadMatch(loadQ102H, rs2Q101H) || loadMatch(loadQ103H, rs2Q101H);

assign loadHazardQ101H = rs1Hit || (rs2Hit && rs2UsedQ101H);

// ------------------------------
// Branch and jump flush
// ------------------------------
assign flushQ102H = jumpQ102H || (branchQ102H && branchCondMetQ102H);   // Target chosen in Q102

// Second wrong-path slot
always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
        flushQ103H <= 1'b0;
    end else if (readyQ103H) begin
        flushQ103H <= flushQ102H;
    end
end

endmodule

`default_nettype wire

/* ctrlPipe.sv */
`timescale 1ns/10ps
`default_nettype none

module ctrlPipe
    import ctrlPkg::*;
(
    input  logic        Clock,
    input  logic        rstN,
    input  logic        dMemReady,
    input  tDecodedCtrl ctrlQ101H,
    input  logic        loadHazardQ101H,
    input  logic        flushQ102H,
    input  logic        flushQ103H,
    output tLoadDst     loadQ102H,
    output tLoadDst     loadQ103H,
    output logic        jumpQ102H,
    output logic        branchQ102H,
    output logic        readyQ100H,
    output logic        readyQ101H,
    output tCtrlIf      ctrlIf,
    output tCtrlRf      ctrlRf,
    output tCtrlExe     ctrlExe,
    output tCtrlMem     ctrlMem,
    output tCtrlWb      ctrlWb,
    output logic        validInstQ105H
);

// Index n below means stage Q10n
logic [5:0]  readyStage;
logic [5:1]  validStage;          // Valid bits after ready gating
logic [5:2]  preValid;            // Registered valid bits
logic        bubbleQ101H;
tDecodedCtrl stageSrc  [2:5];     // Input of each stage register
tDecodedCtrl stageCtrl [2:5];

// ------------------------------
// Ready levels
// ------------------------------
assign readyStage[5:2] = {4{dMemReady}};   // Only data memory stalls the back end
assign readyStage[1]   = (dMemReady && !loadHazardQ101H) || flushQ102H || flushQ103H;
assign readyStage[0]   = dMemReady && readyStage[1];
assign readyQ100H      = readyStage[0];
assign readyQ101H      = readyStage[1];

assign bubbleQ101H = flushQ102H || flushQ103H || loadHazardQ101H;   // Kill Q101, keep its bits

always_comb begin
    validStage[1] = readyStage[1] && !bubbleQ101H;
    for (int n = 2; n <= 5; n++) begin
        validStage[n] = readyStage[n] && preValid[n];
    end
end

// ------------------------------
// Stage registers
// ------------------------------
always_comb begin
    stageSrc[2] = ctrlQ101H;
    for (int n = 3; n <= 5; n++) begin
        stageSrc[n] = stageCtrl[n-1];
    end
end

always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
        preValid <= '0;
    end else begin
        for (int n = 2; n <= 5; n++) begin
            if (readyStage[n]) begin
                preValid[n] <= validStage[n-1];   // Hold while frozen
            end
        end
    end
end

always_ff @(posedge Clock) begin
    for (int n = 2; n <= 5; n++) begin
        if (readyStage[n]) begin
            stageCtrl[n] <= stageSrc[n];
        end
    end
end

// ------------------------------
// To the hazard detector
// ------------------------------
assign loadQ102H.valid  = validStage[2] && stageCtrl[2].dMemRdEn;   // Only LOAD reads memory
assign loadQ102H.regDst = stageCtrl[2].regDst;
assign loadQ103H.valid  = validStage[3] && stageCtrl[3].dMemRdEn;
assign loadQ103H.regDst = stageCtrl[3].regDst;
assign jumpQ102H        = validStage[2] && stageCtrl[2].selNextPcJump;
assign branchQ102H      = validStage[2] && stageCtrl[2].selNextPcBranch;

// ------------------------------
// Grouped outputs
// ------------------------------
assign ctrlIf.selNextPcAluOutQ102H = flushQ102H;   // Taken branch or jump

assign ctrlRf.regSrc1Q101H = ctrlQ101H.regSrc1;    // Read ports in decode
assign ctrlRf.regSrc2Q101H = ctrlQ101H.regSrc2;
assign ctrlRf.regDstQ105H  = stageCtrl[5].regDst;
assign ctrlRf.regWrEnQ105H = validStage[5] && stageCtrl[5].regWrEn;

assign ctrlExe.aluOpQ102H     = stageCtrl[2].aluOp;
assign ctrlExe.branchOpQ102H  = stageCtrl[2].branchOp;
assign ctrlExe.luiQ102H       = stageCtrl[2].lui;
assign ctrlExe.selAluPcQ102H  = stageCtrl[2].selAluPc;
assign ctrlExe.selAluImmQ102H = stageCtrl[2].selAluImm;
assign ctrlExe.regSrc1Q102H   = stageCtrl[2].regSrc1;
assign ctrlExe.regSrc2Q102H   = stageCtrl[2].regSrc2;
assign ctrlExe.regDstQ103H    = stageCtrl[3].regDst;   // Forwarding compares
assign ctrlExe.regWrEnQ103H   = validStage[3] && stageCtrl[3].regWrEn;
assign ctrlExe.regDstQ104H    = stageCtrl[4].regDst;
assign ctrlExe.regWrEnQ104H   = validStage[4] && stageCtrl[4].regWrEn;
assign ctrlExe.regDstQ105H    = stageCtrl[5].regDst;
assign ctrlExe.regWrEnQ105H   = validStage[5] && stageCtrl[5].regWrEn;

assign ctrlMem.dMemWrEnQ103H   = validStage[3] && stageCtrl[3].dMemWrEn;
assign ctrlMem.dMemRdEnQ103H   = validStage[3] && stageCtrl[3].dMemRdEn;
assign ctrlMem.dMemByteEnQ103H = stageCtrl[3].dMemByteEn;

assign ctrlWb.byteEnQ105H  = stageCtrl[5].dMemByteEn;   // Load data alignment
assign ctrlWb.signExtQ105H = stageCtrl[5].signExt;
assign ctrlWb.wbSelQ105H   = stageCtrl[5].wbSel;

assign validInstQ105H = validStage[5];   // Retire strobe

endmodule

`default_nettype wire

/* coreCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module coreCtrl
    import ctrlPkg::*;
(
    input  logic            Clock,
    input  logic            rstN,
    input  logic            dMemReady,
    input  logic            branchCondMetQ102H,
    input  logic [XLEN-1:0] instructionQ101H,
    output logic            readyQ100H,
    output logic            readyQ101H,
    output tCtrlIf          ctrlIf,
    output tCtrlRf          ctrlRf,
    output tCtrlExe         ctrlExe,
    output tCtrlMem         ctrlMem,
    output tCtrlWb          ctrlWb,
    output logic [XLEN-1:0] immediateQ101H,
    output logic            validInstQ105H
);

tDecodedCtrl ctrlQ101H;
tLoadDst     loadQ102H;
tLoadDst     loadQ103H;
logic        jumpQ102H;
logic        branchQ102H;
logic        loadHazardQ101H;
logic        flushQ102H;
logic        flushQ103H;

// ------------------------------
// Decode and hazards side by side
// ------------------------------
instrDecoder i_decoder (
    .instructionQ101H (instructionQ101H),
    .ctrlQ101H        (ctrlQ101H),
    .immediateQ101H   (immediateQ101H)
);

hazardDetect i_hazard (
    .Clock              (Clock),
    .rstN               (rstN),
    .readyQ103H         (dMemReady),   // Q103 ready is the memory level
    .instructionQ101H   (instructionQ101H),
    .loadQ102H          (loadQ102H),
    .loadQ103H          (loadQ103H),
    .jumpQ102H          (jumpQ102H),
    .branchQ102H        (branchQ102H),
    .branchCondMetQ102H (branchCondMetQ102H),
    .loadHazardQ101H    (loadHazardQ101H),
    .flushQ102H         (flushQ102H),
    .flushQ103H         (flushQ103H)
);

ctrlPipe i_pipe (
    .Clock           (Clock),
    .rstN            (rstN),
    .dMemReady       (dMemReady),
    .ctrlQ101H       (ctrlQ101H),
    .loadHazardQ101H (loadHazardQ101H),
    .flushQ102H      (flushQ102H),
    .flushQ103H      (flushQ103H),
    .loadQ102H       (loadQ102H),
    .loadQ103H       (loadQ103H),
    .jumpQ102H       (jumpQ102H),
    .branchQ102H     (branchQ102H),
    .readyQ100H      (readyQ100H),
    .readyQ101H      (readyQ101H),
    .ctrlIf          (ctrlIf),
    .ctrlRf          (ctrlRf),
    .ctrlExe         (ctrlExe),
    .ctrlMem         (ctrlMem),
    .ctrlWb          (ctrlWb),
    .validInstQ105H  (validInstQ105H)
);

endmodule

`default_nettype wire

/* coreCtrl_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module coreCtrl_checker
    import ctrlPkg::*;
(
    input logic    Clock,
    input logic    rstN,
    input logic    dMemReady,
    input logic    readyQ101H,
    input logic    validInstQ105H,
    input tCtrlIf  ctrlIf,
    input tCtrlRf  ctrlRf,
    input tCtrlMem ctrlMem
);

// ------------------------------
// Protocol properties
// ------------------------------
flushAdvances: assert property (@(posedge Clock) disable iff (!rstN)
    ctrlIf.selNextPcAluOutQ102H |-> readyQ101H)
    else $error("flush without readyQ101H");

memOneAccess: assert property (@(posedge Clock) disable iff (!rstN)
    !(ctrlMem.dMemWrEnQ103H && ctrlMem.dMemRdEnQ103H))
    else $error("read and write enables both high");   // One access per cycle

retireNeedsMem: assert property (@(posedge Clock) disable iff (!rstN)
    validInstQ105H |-> dMemReady)
    else $error("retire while data memory not ready");

resetQuiet: assert property (@(posedge Clock)
    !rstN |-> !(ctrlMem.dMemWrEnQ103H || ctrlMem.dMemRdEnQ103H || ctrlRf.regWrEnQ105H))
    else $error("enables active during reset");

endmodule

bind coreCtrl coreCtrl_checker i_checker (
    .Clock (Clock), .rstN (rstN), .dMemReady (dMemReady), .readyQ101H (readyQ101H),
    .validInstQ105H (validInstQ105H), .ctrlIf (ctrlIf), .ctrlRf (ctrlRf), .ctrlMem (ctrlMem)
);

`default_nettype wire

/* coreCtrlTb.sv */
`timescale 1ns/10ps
`default_nettype none

module coreCtrlTb
    import ctrlPkg::*;
();

localparam int MAX_CYCLES = 400;   // Tests need about 150
localparam logic [31:0] NOP = 32'h0000_0013;   // addi x0, x0, 0

logic            Clock;
logic            rstN;
logic            dMemReady;
logic            branchCondMetQ102H;
logic [XLEN-1:0] instructionQ101H;
logic            readyQ100H;
logic            readyQ101H;
tCtrlIf          ctrlIf;
tCtrlRf          ctrlRf;
tCtrlExe         ctrlExe;
tCtrlMem         ctrlMem;
tCtrlWb          ctrlWb;
logic [XLEN-1:0] immediateQ101H;
logic            validInstQ105H;

int          seed = 12;
int          cycleCount = 0;
int          errors = 0;
int          passCount = 0;
int          failCount = 0;
logic [31:0] rnd;
logic [4:0]  retired [$];   // Destinations seen at Q105 in order

coreCtrl i_dut (
    .Clock (Clock), .rstN (rstN), .dMemReady (dMemReady),
    .branchCondMetQ102H (branchCondMetQ102H), .instructionQ101H (instructionQ101H),
    .readyQ100H (readyQ100H), .readyQ101H (readyQ101H),
    .ctrlIf (ctrlIf), .ctrlRf (ctrlRf), .ctrlExe (ctrlExe), .ctrlMem (ctrlMem),
    .ctrlWb (ctrlWb), .immediateQ101H (immediateQ101H), .validInstQ105H (validInstQ105H)
);

initial Clock = 1'b0;
always #50 Clock = ~Clock;   // 100 ns period

always @(posedge Clock) begin
    cycleCount++;
    if (cycleCount >= MAX_CYCLES) begin
        $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Regression failed");
        $finish;
    end
end

// ------------------------------
// Instruction encoders
// ------------------------------
function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// ------------------------------
// Drive and bookkeeping
// ------------------------------
task automatic logError(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors++;
endtask

// Drive on the falling edge and sample once settled
task automatic driveCycle(input logic [31:0] instr, input logic cond, input logic memRdy);
    @(negedge Clock);
    instructionQ101H   = instr;
    branchCondMetQ102H = cond;
    dMemReady          = memRdy;
    #1;
    if (validInstQ105H && ctrlRf.regWrEnQ105H && ctrlRf.regDstQ105H != 5'd0) begin
        retired.push_back(ctrlRf.regDstQ105H);
    end
endtask

task automatic tick(input logic [31:0] instr);
    driveCycle(instr, 1'b0, 1'b1);
endtask

task automatic drain(input int n);
    repeat (n) tick(NOP);
endtask

task automatic reportTest(input string name, input int errBefore);
    if (errors == errBefore) begin
        passCount++;
        $display("%s: ok", name);
    end else begin
        failCount++;
        $display("%s: %0d errors", name, errors - errBefore);
    end
endtask

// ------------------------------
// Directed tests
// ------------------------------
task automatic checkDecode(input string name, input logic [31:0] instr,
                           input logic [31:0] expImm, input tAluOp expAlu,
                           input logic expPc, input logic expImmSel, input logic expLui,
                           input logic [4:0] expRs1, input logic [4:0] expRs2);
    tick(instr);
    if (immediateQ101H !== expImm) logError($sformatf("%s imm %h", name, immediateQ101H));
    if (ctrlRf.regSrc1Q101H !== expRs1) logError($sformatf("%s regSrc1Q101H", name));
    if (ctrlRf.regSrc2Q101H !== expRs2) logError($sformatf("%s regSrc2Q101H", name));
    tick(NOP);   // Now in Q102
    if (ctrlExe.aluOpQ102H !== expAlu) logError($sformatf("%s aluOp", name));
    if (ctrlExe.selAluPcQ102H !== expPc) logError($sformatf("%s selAluPc", name));
    if (ctrlExe.selAluImmQ102H !== expImmSel) logError($sformatf("%s selAluImm", name));
    if (ctrlExe.luiQ102H !== expLui) logError($sformatf("%s lui", name));
    if (ctrlExe.branchOpQ102H !== BEQ) logError($sformatf("%s branchOp", name));
    if (ctrlExe.regSrc1Q102H !== expRs1) logError($sformatf("%s regSrc1", name));
    if (ctrlExe.regSrc2Q102H !== expRs2) logError($sformatf("%s regSrc2", name));
endtask

task automatic testDecode();
    int errBefore;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [12:0] imm13;
    logic [20:0] imm21;
    errBefore = errors;
    rnd = $random(seed);
    rd = rnd[4:0];
    rs1 = rnd[9:5];
    rs2 = rnd[14:10];
    imm12 = rnd[31:20];
    imm20 = rnd[31:12];
    imm13 = {rnd[27:16], 1'b0};
    imm21 = {rnd[30:11], 1'b0};
    checkDecode("add", rType(7'b0, rs2, rs1, 3'b000, rd), {27'b0, rs2}, ADD, 0, 0, 0, rs1,
                rs2);
    checkDecode("sub", rType(7'b0100000, rs2, rs1, 3'b000, rd), {20'b0, 7'b0100000, rs2},
                SUB, 0, 0, 0, rs1, rs2);
    checkDecode("addi", iType(imm12, rs1, 3'b000, rd, I_OP), {{20{imm12[11]}}, imm12},
                ADD, 0, 1, 0, rs1, imm12[4:0]);
    checkDecode("srai", iType({7'b0100000, rs2}, rs1, 3'b101, rd, I_OP),
                {20'b0, 7'b0100000, rs2}, SRA, 0, 1, 0, rs1, rs2);
    checkDecode("lui", {imm20, rd, 7'b0110111}, {imm20, 12'b0}, ADD, 0, 1, 1, imm20[7:3],
                imm20[12:8]);
    checkDecode("auipc", {imm20, rd, 7'b0010111}, {imm20, 12'b0}, ADD, 1, 1, 0, imm20[7:3],
                imm20[12:8]);
    checkDecode("jal", jType(imm21, rd), {{11{imm21[20]}}, imm21}, ADD, 1, 1, 0,
                imm21[19:15], {imm21[4:1], imm21[11]});
    checkDecode("beq", bType(imm13, rs2, rs1, 3'b000), {{19{imm13[12]}}, imm13},
                ADD, 1, 1, 0, rs1, rs2);
    checkDecode("sw", sType(imm12, rs2, rs1, 3'b010), {{20{imm12[11]}}, imm12},
                ADD, 0, 1, 0, rs1, rs2);
    drain(3);
    reportTest("decode and immediate", errBefore);
endtask

task automatic testLatency();
    int errBefore;
    logic [4:0] rd;
    errBefore = errors;
    rnd = $random(seed);
    rd = rnd[4:0];
    if (rd == 5'd0) rd = 5'd1;   // x0 would look like the NOPs around it
    tick(iType(12'h001, 5'd1, 3'b000, rd, I_OP));
    drain(2);   // Q103
    if (!ctrlExe.regWrEnQ103H) logError("addi regWrEn low at Q103");
    if (ctrlExe.regDstQ103H !== rd) logError("addi regDst at Q103");
    drain(1);   // Q104
    if (!ctrlExe.regWrEnQ104H) logError("addi regWrEn low at Q104");
    if (ctrlExe.regDstQ104H !== rd) logError("addi regDst at Q104");
    drain(1);   // Q105
    if (!validInstQ105H) logError("addi not valid at Q105");
    if (!ctrlRf.regWrEnQ105H) logError("addi regWrEn low at Q105");
    if (ctrlRf.regDstQ105H !== rd) logError("addi regDst at Q105");
    if (!ctrlExe.regWrEnQ105H) logError("addi forwarding regWrEn low at Q105");
    if (ctrlExe.regDstQ105H !== rd) logError("addi forwarding regDst at Q105");
    tick(sType(12'h010, 5'd3, 5'd2, 3'b010));
    drain(2);
    if (!ctrlMem.dMemWrEnQ103H) logError("sw dMemWrEn low at Q103");
    if (ctrlExe.regWrEnQ103H) logError("sw regWrEn high at Q103");
    drain(3);
    reportTest("pipeline latency", errBefore);
endtask

// Holds the instruction while stalled and returns the stall length
task automatic countStall(input logic [31:0] instr, output int n);
    n = 0;
    tick(instr);
    while (!readyQ101H && n < 8) begin
        if (readyQ100H) logError("readyQ100H high during stall");
        n++;
        tick(instr);
    end
endtask

task automatic testLoadUse();
    int errBefore;
    int n;
    logic [31:0] lw5;
    errBefore = errors;
    lw5 = iType(12'h004, 5'd1, 3'b010, 5'd5, LOAD);
    tick(lw5);
    countStall(rType(7'b0, 5'd7, 5'd5, 3'b000, 5'd6), n);
    if (n != 2) logError($sformatf("back-to-back stall %0d cycles", n));
    drain(2);
    tick(lw5);
    tick(iType(12'h003, 5'd0, 3'b000, 5'd8, I_OP));   // Unrelated
    countStall(rType(7'b0, 5'd7, 5'd5, 3'b000, 5'd6), n);
    if (n != 1) logError($sformatf("separated stall %0d cycles", n));
    drain(2);
    tick(lw5);
    countStall(iType(12'h005, 5'd9, 3'b000, 5'd10, I_OP), n);   // rs2 field is x5
    if (n != 0) logError($sformatf("i-type stalled %0d cycles", n));
    drain(4);
    reportTest("load-use stall", errBefore);
endtask

task automatic branchRun(input logic taken);
    retired.delete();
    tick(bType(13'h008, 5'd2, 5'd1, 3'b000));
    driveCycle(iType(12'h001, 5'd0, 3'b000, 5'd11, I_OP), taken, 1'b1);
    if (ctrlIf.selNextPcAluOutQ102H !== taken) logError("selNextPcAluOutQ102H");
    tick(iType(12'h002, 5'd0, 3'b000, 5'd12, I_OP));
    drain(6);
    if (taken && retired.size() != 0) logError("flushed instruction retired");
    if (!taken && (retired.size() != 2 || retired[0] != 5'd11 || retired[1] != 5'd12)) begin
        logError("fall-through instructions did not retire");
    end
endtask

task automatic testBranch();
    int errBefore;
    errBefore = errors;
    branchRun(1'b1);
    branchRun(1'b0);
    reportTest("branch flush", errBefore);
endtask

task automatic testFreeze();
    int errBefore;
    errBefore = errors;
    retired.delete();
    tick(iType(12'h001, 5'd0, 3'b000, 5'd13, I_OP));
    tick(iType(12'h002, 5'd0, 3'b000, 5'd14, I_OP));
    tick(iType(12'h003, 5'd0, 3'b000, 5'd15, I_OP));
    repeat (3) begin
        driveCycle(NOP, 1'b0, 1'b0);   // Data memory busy
        if (readyQ100H) logError("readyQ100H high while frozen");
        if (validInstQ105H) logError("validInstQ105H high while frozen");
    end
    drain(6);
    if (retired.size() != 3 || retired[0] != 5'd13 || retired[1] != 5'd14 ||
        retired[2] != 5'd15) begin
        logError($sformatf("%0d instructions retired after freeze", retired.size()));
    end
    reportTest("memory freeze", errBefore);
endtask

task automatic checkMemOp(input string name, input logic [31:0] instr,
                          input logic [3:0] expBe, input logic isLoad, input logic expSign);
    tick(instr);
    drain(2);   // Q103
    if (ctrlMem.dMemByteEnQ103H !== expBe) logError($sformatf("%s byteEn Q103", name));
    if (ctrlMem.dMemRdEnQ103H !== isLoad) logError($sformatf("%s dMemRdEn", name));
    if (ctrlMem.dMemWrEnQ103H !== !isLoad) logError($sformatf("%s dMemWrEn", name));
    drain(2);   // Q105
    if (isLoad) begin
        if (ctrlWb.byteEnQ105H !== expBe) logError($sformatf("%s byteEn Q105", name));
        if (ctrlWb.signExtQ105H !== expSign) logError($sformatf("%s signExt", name));
        if (ctrlWb.wbSelQ105H !== WB_DMEM) logError($sformatf("%s wbSel", name));
    end
endtask

task automatic testMemSizes();
    int errBefore;
    errBefore = errors;
    checkMemOp("lb", iType(12'h000, 5'd2, 3'b000, 5'd16, LOAD), 4'b0001, 1, 1);
    checkMemOp("lhu", iType(12'h002, 5'd2, 3'b101, 5'd17, LOAD), 4'b0011, 1, 0);
    checkMemOp("lw", iType(12'h004, 5'd2, 3'b010, 5'd18, LOAD), 4'b1111, 1, 1);
    checkMemOp("sh", sType(12'h006, 5'd3, 5'd2, 3'b001), 4'b0011, 0, 0);
    reportTest("loads and stores by size", errBefore);
endtask

// ------------------------------
// Main sequence
// ------------------------------
initial begin
    rstN               = 1'b0;
    dMemReady          = 1'b1;
    branchCondMetQ102H = 1'b0;
    instructionQ101H   = NOP;
    repeat (5) @(posedge Clock);
    @(negedge Clock);
    rstN = 1'b1;
    testDecode();
    testLatency();
    testLoadUse();
    testBranch();
    testFreeze();
    testMemSizes();
    $display("tests: %0d passed, %0d failed, %0d mismatches", passCount, failCount, errors);
    if (failCount == 0 && errors == 0) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

endmodule

`default_nettype wire

/* list.f */
ctrlPkg.sv
instrDecoder.sv
hazardDetect.sv
ctrlPipe.sv
coreCtrl.sv
coreCtrl_checker.sv
coreCtrlTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the coreCtrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module coreCtrlTb -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Regression passed"; then
    exit 0
fi
exit 1
